/* Bender.yml */
package:
  name: rv_exe_stage

sources:
  - files:
      - source/rv_exe_pkg.sv
      - source/rv_operand_sel.sv
      - source/rv_alu.sv
      - source/rv_branch_unit.sv
      - source/rv_exe_stage.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/rv_exe_chk.sv
      - tb/rv_exe_tb.sv

/* sim.f */
source/rv_exe_pkg.sv
source/rv_operand_sel.sv
source/rv_alu.sv
source/rv_branch_unit.sv
source/rv_exe_stage.sv
tb/tb_clk_gen.sv
tb/rv_exe_chk.sv
tb/rv_exe_tb.sv

/* source/rv_alu.sv */
// ========================================
// Execute ALU
// Result, write enable and address per opcode
// ========================================
`timescale 1ns/1ps

module rv_alu (
  input  logic [4:0]                  opcode,
  input  logic [2:0]                  funct3,
  input  logic [6:0]                  funct7,
  input  logic [rv_exe_pkg::XLEN-1:0] op1,
  input  logic [rv_exe_pkg::XLEN-1:0] op2,
  input  logic [rv_exe_pkg::XLEN-1:0] t1,
  output logic                        rd_wen,
  output logic [rv_exe_pkg::XLEN-1:0] rd_data,
  output logic [rv_exe_pkg::XLEN-1:0] mem_addr
);
  import rv_exe_pkg::*;

  logic            sub_en;   // SUB or SUBW
  logic [XLEN-1:0] add_d;
  logic [XLEN-1:0] sra_d;
  logic [31:0]     w_add;
  logic [31:0]     w_sll;
  logic [31:0]     w_srl;
  logic [31:0]     w_sra;

  // Sign extension of a 32-bit word result
  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  // Immediate forms never subtract
  assign sub_en = funct7[5] && (opcode == OPC_OP || opcode == OPC_OP32);

  assign add_d = sub_en ? op1 - op2 : op1 + op2;
  assign sra_d = $signed(op1) >>> op2[5:0];  // Arithmetic shift, sign fills

  // Word forms work on the low 32 bits
  assign w_add = sub_en ? op1[31:0] - op2[31:0] : op1[31:0] + op2[31:0];
  assign w_sll = op1[31:0] << op2[4:0];
  assign w_srl = op1[31:0] >> op2[4:0];
  assign w_sra = $signed(op1[31:0]) >>> op2[4:0];

  always_comb begin
    case (opcode)
      OPC_LUI,
      OPC_AUIPC,
      OPC_JAL,
      OPC_JALR,
      OPC_LOAD,
      OPC_IMM,
      OPC_OP,
      OPC_IMM32,
      OPC_OP32: rd_wen = 1'b1;
      default:  rd_wen = 1'b0;  // Stores, branches and no-ops
    endcase
  end

  always_comb begin
    rd_data = '0;
    case (opcode)
      OPC_LUI:   rd_data = op1;
      OPC_AUIPC: rd_data = op1 + op2;
      OPC_JAL:   rd_data = op1;  // pc + 4
      OPC_JALR:  rd_data = t1;   // pc + 4
      OPC_IMM, OPC_OP: begin
        case (funct3)
          F3_ADD:  rd_data = add_d;
          F3_SLL:  rd_data = op1 << op2[5:0];
          F3_SLT:  rd_data = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
          F3_SLTU: rd_data = {{(XLEN-1){1'b0}}, op1 < op2};
          F3_XOR:  rd_data = op1 ^ op2;
          F3_SR: begin
            if (funct7[5]) begin
              rd_data = sra_d;             // SRA, SRAI
            end else begin
              rd_data = op1 >> op2[5:0];   // SRL, SRLI
            end
          end
          F3_OR:   rd_data = op1 | op2;
          F3_AND:  rd_data = op1 & op2;
          default: rd_data = '0;
        endcase
      end
      OPC_IMM32, OPC_OP32: begin
        case (funct3)
          F3_ADD: rd_data = sext_w(w_add);
          F3_SLL: rd_data = sext_w(w_sll);
          F3_SR: begin
            if (funct7[5]) begin
              rd_data = sext_w(w_sra);
            end else begin
              rd_data = sext_w(w_srl);
            end
          end
          default: rd_data = '0;  // No other W ops in RV64I
        endcase
      end
      default: rd_data = '0;  // Load data merged later
    endcase
  end

  // Effective address for memory ops
  assign mem_addr = (opcode == OPC_LOAD || opcode == OPC_STORE) ? op1 + op2 : '0;

endmodule

/* source/rv_branch_unit.sv */
// ========================================
// Branch resolver
// Jump target, next PC and misprediction flag
// ========================================
`timescale 1ns/1ps

module rv_branch_unit (
  input  logic [4:0]                  opcode,
  input  logic [2:0]                  funct3,
  input  logic [rv_exe_pkg::XLEN-1:0] op1,
  input  logic [rv_exe_pkg::XLEN-1:0] op2,
  input  logic [rv_exe_pkg::XLEN-1:0] t1,
  input  logic [rv_exe_pkg::XLEN-1:0] pc,
  input  logic [rv_exe_pkg::XLEN-1:0] pc_pred,
  output logic [rv_exe_pkg::XLEN-1:0] next_pc,
  output logic                        mispredict
);
  import rv_exe_pkg::*;

  logic            taken;       // Branch condition
  logic            pc_jmp;
  logic [XLEN-1:0] pc_jmpaddr;
  logic [XLEN-1:0] jalr_sum;

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (op1 == op2);
      F3_BNE:  taken = (op1 != op2);
      F3_BLT:  taken = ($signed(op1) < $signed(op2));
      F3_BGE:  taken = ($signed(op1) >= $signed(op2));
      F3_BLTU: taken = (op1 < op2);
      F3_BGEU: taken = (op1 >= op2);
      default: taken = 1'b0;  // Reserved encodings
    endcase
  end

  assign jalr_sum = op1 + op2;

  always_comb begin
    pc_jmp     = 1'b0;
    pc_jmpaddr = '0;
    case (opcode)
      OPC_JAL: begin
        pc_jmp     = 1'b1;
        pc_jmpaddr = op2;
      end
      OPC_JALR: begin
        pc_jmp     = 1'b1;
        pc_jmpaddr = {jalr_sum[XLEN-1:1], 1'b0};  // Bit 0 cleared
      end
      OPC_BRANCH: begin
        pc_jmp     = taken;
        pc_jmpaddr = t1;
      end
      default: ;
    endcase
  end

  assign next_pc    = pc_jmp ? pc_jmpaddr : pc + XLEN'(4);
  assign mispredict = (next_pc != pc_pred);  // Any wrong guess, jumps or not

endmodule

/* source/rv_exe_pkg.sv */
// ========================================
// RV64I execute stage shared definitions
// Widths, opcode and funct3 codes, instruction views
// ========================================
package rv_exe_pkg;

  localparam int XLEN = 64;  // Data and address width
  localparam int ILEN = 32;  // Instruction word width

  // Major opcodes, instruction bits 6:2
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_IMM    = 5'b00100;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_IMM32  = 5'b00110;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_OP32   = 5'b01110;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_JAL    = 5'b11011;

  // Integer op funct3, shared by OP, IMM and the W forms
  localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL, SRA by funct7 bit 5
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;  // Register ops
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;  // Immediate ops, loads, JALR
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;  // Stores, branches reuse it
  } rv_instr_u;

endpackage

/* source/rv_exe_stage.sv */
// ========================================
// RV64I execute stage
// Operand select, ALU, branch resolve, output register
// ========================================
`timescale 1ns/1ps

module rv_exe_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  logic                        stall,
  input  logic [rv_exe_pkg::ILEN-1:0] instr,
  input  logic [rv_exe_pkg::XLEN-1:0] pc,
  input  logic [rv_exe_pkg::XLEN-1:0] pc_pred,
  input  logic [rv_exe_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_exe_pkg::XLEN-1:0] rs2_data,
  output logic                        out_valid,
  output logic                        rd_wen,
  output logic                        mem_ren,
  output logic                        mem_wen,
  output logic                        flush,
  output logic [4:0]                  rd_idx,
  output logic [rv_exe_pkg::XLEN-1:0] rd_data,
  output logic [rv_exe_pkg::XLEN-1:0] mem_addr,
  output logic [rv_exe_pkg::XLEN-1:0] store_data,
  output logic [rv_exe_pkg::XLEN-1:0] flush_pc
);
  import rv_exe_pkg::*;

  logic [4:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] t1;
  logic            alu_rd_wen;
  logic [XLEN-1:0] alu_rd_data;
  logic [XLEN-1:0] alu_mem_addr;
  logic [XLEN-1:0] next_pc;
  logic            mispredict;
  logic            is_load;
  logic            is_store;
  logic            accept;    // Instruction taken this edge

  rv_operand_sel u_operand_sel (
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7   (funct7),
    .op1      (op1),
    .op2      (op2),
    .t1       (t1)
  );

  rv_alu u_alu (
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7   (funct7),
    .op1      (op1),
    .op2      (op2),
    .t1       (t1),
    .rd_wen   (alu_rd_wen),
    .rd_data  (alu_rd_data),
    .mem_addr (alu_mem_addr)
  );

  rv_branch_unit u_branch_unit (
    .opcode     (opcode),
    .funct3     (funct3),
    .op1        (op1),
    .op2        (op2),
    .t1         (t1),
    .pc         (pc),
    .pc_pred    (pc_pred),
    .next_pc    (next_pc),
    .mispredict (mispredict)
  );

  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);
  assign accept   = in_valid && !stall;

  // Valid and enables, held under stall
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rd_wen    <= 1'b0;
      mem_ren   <= 1'b0;
      mem_wen   <= 1'b0;
      flush     <= 1'b0;
    end else if (!stall) begin
      out_valid <= in_valid;  // Idle edge drops the slot
      rd_wen    <= in_valid && alu_rd_wen;
      mem_ren   <= in_valid && is_load;
      mem_wen   <= in_valid && is_store;
      flush     <= in_valid && mispredict;
    end
  end

  // Payload loads only on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_idx     <= instr[11:7];
      rd_data    <= alu_rd_data;
      mem_addr   <= alu_mem_addr;
      store_data <= is_store ? t1 : '0;  // rs2 for stores
      flush_pc   <= next_pc;
    end
  end

endmodule

/* source/rv_operand_sel.sv */
// ========================================
// Operand selector
// Decodes the word, builds immediates, picks op1/op2/t1
// ========================================
`timescale 1ns/1ps

module rv_operand_sel (
  input  rv_exe_pkg::rv_instr_u           instr,
  input  logic [rv_exe_pkg::XLEN-1:0]     pc,
  input  logic [rv_exe_pkg::XLEN-1:0]     rs1_data,
  input  logic [rv_exe_pkg::XLEN-1:0]     rs2_data,
  output logic [4:0]                      opcode,
  output logic [2:0]                      funct3,
  output logic [6:0]                      funct7,
  output logic [rv_exe_pkg::XLEN-1:0]     op1,
  output logic [rv_exe_pkg::XLEN-1:0]     op2,
  output logic [rv_exe_pkg::XLEN-1:0]     t1
);
  import rv_exe_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] pc_inc;  // Sequential PC, link value

  assign opcode = instr.r.opcode[6:2];  // Low two bits always 2'b11
  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.funct7;

  // Sign-extended immediates
  assign imm_i = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{(XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{(XLEN-13){instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                  instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  assign pc_inc = pc + XLEN'(4);

  always_comb begin
    op1 = '0;
    op2 = '0;
    t1  = '0;
    case (opcode)
      OPC_LUI: op1 = imm_u;
      OPC_AUIPC: begin
        op1 = pc;
        op2 = imm_u;
      end
      OPC_JAL: begin
        op1 = pc_inc;         // Link
        op2 = pc + imm_j;     // Target
      end
      OPC_JALR: begin
        op1 = rs1_data;
        op2 = imm_i;
        t1  = pc_inc;
      end
      OPC_BRANCH: begin
        op1 = rs1_data;
        op2 = rs2_data;
        t1  = pc + imm_b;     // Taken target
      end
      OPC_LOAD, OPC_IMM, OPC_IMM32: begin
        op1 = rs1_data;
        op2 = imm_i;
      end
      OPC_STORE: begin
        op1 = rs1_data;
        op2 = imm_s;
        t1  = rs2_data;       // Store data
      end
      OPC_OP, OPC_OP32: begin
        op1 = rs1_data;
        op2 = rs2_data;
      end
      default: ;              // No-op, operands stay zero
    endcase
  end

endmodule

/* tb/rv_exe_chk.sv */
// ========================================
// Execute stage output checker
// ========================================
`timescale 1ns/1ps

module rv_exe_chk (
  input logic                        clk,
  input logic                        rst,
  input logic                        stall,
  input logic                        out_valid,
  input logic                        rd_wen,
  input logic                        mem_ren,
  input logic                        mem_wen,
  input logic                        flush,
  input logic [4:0]                  rd_idx,
  input logic [rv_exe_pkg::XLEN-1:0] rd_data,
  input logic [rv_exe_pkg::XLEN-1:0] mem_addr,
  input logic [rv_exe_pkg::XLEN-1:0] store_data,
  input logic [rv_exe_pkg::XLEN-1:0] flush_pc
);

  int fail_cnt = 0;  // Assertion failures so far

  // Empty slot carries no side effects
  idle_quiet: assert property (@(posedge clk) disable iff (rst)
    !out_valid |-> !(rd_wen || mem_ren || mem_wen || flush))
    else begin
      $error("Enable or flush high while out_valid is low");
      fail_cnt++;
    end

  stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && stall |=> out_valid && $stable(rd_wen) && $stable(mem_ren) &&
      $stable(mem_wen) && $stable(flush) && $stable(rd_idx) && $stable(rd_data) &&
      $stable(mem_addr) && $stable(store_data) && $stable(flush_pc))
    else begin
      $error("Stage outputs changed during a stall");
      fail_cnt++;
    end

  reset_clear: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_cnt++;
    end

endmodule

/* tb/rv_exe_tb.sv */
// ========================================
// RV64I execute stage testbench
// Random instructions against a reference model
// ========================================
`timescale 1ns/1ps

module rv_exe_tb;
  import rv_exe_pkg::*;

  typedef struct packed {
    logic            rd_wen;
    logic            mem_ren;
    logic            mem_wen;
    logic            flush;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] flush_pc;
  } exp_t;

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic            stall;
  logic [ILEN-1:0] instr;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_pred;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            out_valid;
  logic            rd_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic            flush;
  logic [4:0]      rd_idx;
  logic [XLEN-1:0] rd_data;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] store_data;
  logic [XLEN-1:0] flush_pc;
  exp_t            exp_q[$];
  logic            exp_valid;   // Modeled out_valid
  int              checked = 0;
  int              cycles = 0;
  logic [4:0] kinds [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                             OPC_STORE, OPC_IMM, OPC_OP, OPC_IMM32, OPC_OP32};
  logic [2:0] w_ops [3] = '{F3_ADD, F3_SLL, F3_SR};  // W forms in RV64I

  tb_clk_gen u_clk_gen (.clk(clk));

  rv_exe_stage UUT (.*);

  bind rv_exe_stage rv_exe_chk u_chk (.*);

  // Sign-extend the low bits of v
  function automatic logic [XLEN-1:0] sext(input logic [XLEN-1:0] v, input int bits);
    logic [XLEN-1:0] mask;
    mask = (XLEN'(1) << bits) - 1;
    return v[bits-1] ? (v | ~mask) : (v & mask);
  endfunction

  function automatic logic [XLEN-1:0] alu64(input logic [2:0] f3, input logic sub,
                                            input logic sra, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [5:0]      sh;
    logic [XLEN-1:0] msb;
    logic [XLEN-1:0] r;
    sh  = b[5:0];
    msb = {1'b1, {(XLEN-1){1'b0}}};
    r   = '0;
    case (f3)
      F3_ADD:  r = sub ? a - b : a + b;
      F3_SLL:  r = a << sh;
      F3_SLT:  r = XLEN'((a ^ msb) < (b ^ msb));  // Signed compare via sign flip
      F3_SLTU: r = XLEN'(a < b);
      F3_XOR:  r = a ^ b;
      F3_SR: begin
        r = a >> sh;
        if (sra && a[XLEN-1]) r = r | ~({XLEN{1'b1}} >> sh);
      end
      F3_OR:   r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [XLEN-1:0] alu32(input logic [2:0] f3, input logic sub,
                                            input logic sra, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    x = a[31:0];
    y = b[31:0];
    r = '0;
    case (f3)
      F3_ADD: r = sub ? x - y : x + y;
      F3_SLL: r = x << y[4:0];
      F3_SR: begin
        r = x >> y[4:0];
        if (sra && x[31]) r = r | ~(32'hffff_ffff >> y[4:0]);
      end
      default: r = '0;
    endcase
    return sext(r, 32);
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    logic lt;
    lt = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return lt;
      F3_BGE:  return !lt;
      F3_BLTU: return a < b;
      F3_BGEU: return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  // Expected stage outputs for one instruction
  function automatic exp_t ref_exec(input rv_instr_u ins, input logic [XLEN-1:0] pc_v,
                                    input logic [XLEN-1:0] pred, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    exp_t            e;
    logic [4:0]      opc;
    logic            alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] nxt;
    opc   = ins.r.opcode[6:2];
    alt   = ins.r.funct7[5];
    imm_i = sext(ins.i.imm12, 12);
    src2  = (opc == OPC_OP || opc == OPC_OP32) ? b : imm_i;
    nxt   = pc_v + 4;
    e     = '0;
    e.rd_idx = ins.r.rd;
    case (opc)
      OPC_LUI: begin
        e.rd_wen  = 1'b1;
        e.rd_data = sext({ins[31:12], 12'h000}, 32);
      end
      OPC_AUIPC: begin
        e.rd_wen  = 1'b1;
        e.rd_data = pc_v + sext({ins[31:12], 12'h000}, 32);
      end
      OPC_JAL: begin
        e.rd_wen  = 1'b1;
        e.rd_data = pc_v + 4;
        nxt = pc_v + sext({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
      end
      OPC_JALR: begin
        e.rd_wen  = 1'b1;
        e.rd_data = pc_v + 4;
        nxt = (a + imm_i) & ~XLEN'(1);
      end
      OPC_BRANCH: begin
        if (branch_taken(ins.r.funct3, a, b)) begin
          nxt = pc_v + sext({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
        end
      end
      OPC_LOAD: begin
        e.rd_wen   = 1'b1;   // Data itself comes later
        e.mem_ren  = 1'b1;
        e.mem_addr = a + imm_i;
      end
      OPC_STORE: begin
        e.mem_wen    = 1'b1;
        e.mem_addr   = a + sext({ins.s.imm_hi, ins.s.imm_lo}, 12);
        e.store_data = b;
      end
      OPC_IMM, OPC_OP: begin
        e.rd_wen  = 1'b1;
        e.rd_data = alu64(ins.r.funct3, alt && opc == OPC_OP, alt, a, src2);
      end
      OPC_IMM32, OPC_OP32: begin
        e.rd_wen  = 1'b1;
        e.rd_data = alu32(ins.r.funct3, alt && opc == OPC_OP32, alt, a, src2);
      end
      default: ;
    endcase
    e.flush    = (nxt != pred);
    e.flush_pc = nxt;
    return e;
  endfunction

  // Random legal encoding of one supported kind
  function automatic rv_instr_u gen_instr();
    rv_instr_u  w;
    logic [4:0] opc;
    logic       alt;
    w   = $urandom;
    opc = kinds[$urandom_range(10, 0)];
    alt = $urandom_range(1, 0);
    case (opc)
      OPC_OP: w.r.funct7 = (alt && w.r.funct3 inside {F3_ADD, F3_SR}) ? 7'h20 : 7'h00;
      OPC_OP32: begin
        w.r.funct3 = w_ops[$urandom_range(2, 0)];
        w.r.funct7 = (alt && w.r.funct3 != F3_SLL) ? 7'h20 : 7'h00;
      end
      OPC_IMM: begin
        if (w.r.funct3 inside {F3_SLL, F3_SR}) begin
          w.i.imm12[11:6] = {1'b0, alt && w.r.funct3 == F3_SR, 4'h0};  // 6-bit shamt
        end
      end
      OPC_IMM32: begin
        w.r.funct3 = w_ops[$urandom_range(2, 0)];
        if (w.r.funct3 != F3_ADD) begin
          w.i.imm12[11:5] = {1'b0, alt && w.r.funct3 == F3_SR, 5'h00};
        end
      end
      OPC_BRANCH: begin
        if (w.r.funct3 inside {3'b010, 3'b011}) w.r.funct3[2] = 1'b1;  // Reserved codes
      end
      default: ;
    endcase
    w.r.opcode = {opc, 2'b11};
    return w;
  endfunction

  task automatic check_val(input string name, input logic [XLEN-1:0] exp_v,
                           input logic [XLEN-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // Expectation enters the queue on the accepting edge
  always @(posedge clk) begin
    if (rst) begin
      exp_valid <= 1'b0;
    end else if (!stall) begin
      exp_valid <= in_valid;
      if (in_valid) exp_q.push_back(ref_exec(instr, pc, pc_pred, rs1_data, rs2_data));
    end
  end

  // A result is consumed on an edge with stall low
  always @(negedge clk) begin
    exp_t e;
    if (!rst) begin
      if (UUT.u_chk.fail_cnt != 0) begin
        $display("A bound assertion on the stage outputs failed");
        $display("STATUS: FAIL");
        $fatal(1);
      end else begin
        check_val("out_valid", exp_valid, out_valid);
        if (out_valid && !stall) begin
          if (exp_q.size() == 0) begin
            $display("A result appeared with no accepted instruction pending");
            $display("STATUS: FAIL");
            $fatal(1);
          end else begin
            e = exp_q.pop_front();
            check_val("rd_wen", e.rd_wen, rd_wen);
            check_val("rd_idx", e.rd_idx, rd_idx);
            check_val("rd_data", e.rd_data, rd_data);
            check_val("mem_ren", e.mem_ren, mem_ren);
            check_val("mem_wen", e.mem_wen, mem_wen);
            check_val("mem_addr", e.mem_addr, mem_addr);
            check_val("store_data", e.store_data, store_data);
            check_val("flush", e.flush, flush);
            check_val("flush_pc", e.flush_pc, flush_pc);
            checked++;
          end
        end
      end
    end
  end

  initial begin
    exp_t probe;
    void'($urandom(32'hfac7));
    rst      = 1'b1;
    in_valid = 1'b0;
    stall    = 1'b0;
    instr    = 32'h0000_0013;  // ADDI x0, x0, 0
    pc       = '0;
    pc_pred  = '0;
    rs1_data = '0;
    rs2_data = '0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    while (checked < 2000 && cycles < 20000) begin
      if (!(in_valid && stall)) begin  // A stalled offer stays on the inputs
        in_valid = ($urandom_range(4, 0) != 0);
        instr    = gen_instr();
        pc       = {$urandom, $urandom} & ~XLEN'(3);
        rs1_data = {$urandom, $urandom};
        rs2_data = ($urandom_range(3, 0) == 0) ? rs1_data : {$urandom, $urandom};
        probe    = ref_exec(instr, pc, '0, rs1_data, rs2_data);
        pc_pred  = $urandom_range(1, 0) ? probe.flush_pc : ({$urandom, $urandom} & ~XLEN'(3));
      end
      stall = ($urandom_range(3, 0) == 0);
      @(posedge clk);
      #1;
      cycles++;
    end
    if (checked < 2000) begin
      $display("Timeout: only %0d results checked in %0d cycles", checked, cycles);
      $display("STATUS: FAIL");
      $fatal(1);
    end else if (UUT.u_chk.fail_cnt != 0) begin
      $display("A bound assertion on the stage outputs failed");
      $display("STATUS: FAIL");
      $fatal(1);
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* tb/tb_clk_gen.sv */
// ========================================
// Testbench clock source, 40 ns period
// ========================================
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk;  // Half period

endmodule
